//--- Bender.yml
package:
  name: exchange

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/replica_pkg.sv
      - hdl/exchange_pkg.sv
      - hdl/bank_rd_if.sv
      - hdl/word_counter.sv
      - hdl/exchange_ctrl.sv
      - hdl/tour_bank.sv
      - hdl/opt_route.sv
      - hdl/exchange.sv
      - target: test
        files:
          - sim/tb_exchange.sv

//--- build.f
+incdir+hdl
hdl/replica_pkg.sv
hdl/exchange_pkg.sv
hdl/bank_rd_if.sv
hdl/word_counter.sv
hdl/exchange_ctrl.sv
hdl/tour_bank.sv
hdl/opt_route.sv
hdl/exchange.sv
sim/tb_exchange.sv

//--- hdl/bank_rd_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

interface bank_rd_if;

    logic                       rd_en;
    logic [`BASE_LOG-1:0]       rd_base;
    logic [`CITY_DIV_LOG-1:0]   rd_word;
    replica_pkg::replica_data_t rd_data;

    modport ctrl (
        output rd_en,
        output rd_base,
        output rd_word
    );

    modport bank (
        input  rd_en,
        input  rd_base,
        input  rd_word,
        output rd_data
    );

endinterface

`default_nettype wire

//--- hdl/exchange.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module exchange (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`BASE_LOG-1:0]            dd_base_id_i,
    input  logic [`BASE_LOG-1:0]            ex_base_id_r_i,
    input  logic [`BASE_LOG-1:0]            ex_base_id_w_i,
    input  exchange_pkg::exchange_command_t command_i,
    input  replica_pkg::opt_t               opt_i,
    input  logic                            prev_valid_i,
    input  replica_pkg::replica_data_t      prev_data_i,
    input  logic                            self_valid_i,
    input  replica_pkg::replica_data_t      self_data_i,
    input  logic                            folw_valid_i,
    input  replica_pkg::replica_data_t      folw_data_i,
    input  exchange_pkg::exchange_command_t in_ex_com_i,
    output logic                            out_valid_o,
    output replica_pkg::replica_data_t      out_data_o,
    input  replica_pkg::city_t              ordering_addr_i,
    output replica_pkg::city_t              ordering_data_o,
    output exchange_pkg::exchange_command_t out_ex_com_o
);

    logic                       wr_valid;
    replica_pkg::replica_data_t wr_data;
    logic [`CITY_DIV_LOG-1:0]   wr_word;
    logic                       load, emit;
    logic [`CITY_DIV_LOG-1:0]   load_word, emit_word;

    bank_rd_if rd_if ();

    // Write source select
    always_comb begin
        case (in_ex_com_i)
            exchange_pkg::PREV: begin
                wr_valid = prev_valid_i;
                wr_data  = prev_data_i;
            end
            exchange_pkg::SELF: begin
                wr_valid = self_valid_i;
                wr_data  = self_data_i;
            end
            exchange_pkg::FOLW: begin
                wr_valid = folw_valid_i;
                wr_data  = folw_data_i;
            end
            default: begin
                wr_valid = 1'b0;
                wr_data  = self_data_i;
            end
        endcase
    end

    word_counter u_wr_cnt (
        .clk     (clk),
        .reset   (reset),
        .en_i    (wr_valid),
        .count_o (wr_word),
        .last_o  ()
    );

    exchange_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .command_i      (command_i),
        .ex_base_id_r_i (ex_base_id_r_i),
        .rd             (rd_if.ctrl),
        .load_o         (load),
        .load_word_o    (load_word),
        .emit_o         (emit),
        .emit_word_o    (emit_word),
        .out_ex_com_o   (out_ex_com_o)
    );

    tour_bank u_bank (
        .clk             (clk),
        .reset           (reset),
        .wr_en_i         (wr_valid),
        .wr_base_i       (ex_base_id_w_i),
        .wr_word_i       (wr_word),
        .wr_data_i       (wr_data),
        .rd              (rd_if.bank),
        .dd_base_id_i    (dd_base_id_i),
        .ordering_addr_i (ordering_addr_i),
        .ordering_data_o (ordering_data_o)
    );

    opt_route u_route (
        .clk         (clk),
        .reset       (reset),
        .opt_i       (opt_i),
        .load_i      (load),
        .load_word_i (load_word),
        .word_i      (rd_if.rd_data),
        .emit_i      (emit),
        .emit_word_i (emit_word),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

endmodule

`default_nettype wire

//--- hdl/exchange_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module exchange_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  exchange_pkg::exchange_command_t  command_i,
    input  logic [`BASE_LOG-1:0]             ex_base_id_r_i,
    bank_rd_if.ctrl                          rd,
    output logic                             load_o,
    output logic [`CITY_DIV_LOG-1:0]         load_word_o,
    output logic                             emit_o,
    output logic [`CITY_DIV_LOG-1:0]         emit_word_o,
    output exchange_pkg::exchange_command_t  out_ex_com_o
);

    exchange_pkg::ctrl_state_t       state_q, state_d;
    exchange_pkg::exchange_command_t com_d1, com_d2, com_d3;
    logic [`CITY_DIV_LOG-1:0]        count;
    logic                            last;
    logic                            cnt_en;
    logic                            start;
    logic                            reading;
    logic [`BASE_LOG-1:0]            rd_base_q;

    assign start   = (state_q == exchange_pkg::IDLE) && (command_i != exchange_pkg::NOP);
    assign reading = (state_q == exchange_pkg::READ);
    assign cnt_en  = (state_q != exchange_pkg::IDLE); // One counter for both phases

    word_counter u_cnt (
        .clk     (clk),
        .reset   (reset),
        .en_i    (cnt_en),
        .count_o (count),
        .last_o  (last)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            exchange_pkg::IDLE: if (start) state_d = exchange_pkg::READ;
            exchange_pkg::READ: if (last) state_d = exchange_pkg::EMIT;
            exchange_pkg::EMIT: if (last) state_d = exchange_pkg::IDLE;
            default:            state_d = exchange_pkg::IDLE;
        endcase
    end

    // ************************************************************
    // State, base capture, pipeline of load and emit strobes
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= exchange_pkg::IDLE;
            rd_base_q <= '0;
            load_o    <= 1'b0;
            emit_o    <= 1'b0;
            com_d1    <= exchange_pkg::NOP;
            com_d2    <= exchange_pkg::NOP;
            com_d3    <= exchange_pkg::NOP;
        end else begin
            state_q <= state_d;
            if (state_q == exchange_pkg::IDLE) rd_base_q <= ex_base_id_r_i; // Frozen while busy
            load_o <= reading;                  // Matches RAM latency
            emit_o <= (state_q == exchange_pkg::EMIT);
            if (start) com_d1 <= command_i;
            com_d2 <= com_d1;
            com_d3 <= com_d2;
        end
    end

    always_ff @(posedge clk) begin
        load_word_o <= count;
        emit_word_o <= count;
    end

    assign rd.rd_en      = reading;
    assign rd.rd_base    = rd_base_q;
    assign rd.rd_word    = count;
    assign out_ex_com_o  = com_d3;

    a_load_emit_excl : assert property (@(posedge clk) disable iff (reset)
        !(load_o && emit_o));

endmodule

`default_nettype wire

//--- hdl/exchange_pkg.sv
`default_nettype none

package exchange_pkg;

    typedef enum logic [1:0] {
        NOP  = 2'd0,
        PREV = 2'd1,
        SELF = 2'd2,
        FOLW = 2'd3
    } exchange_command_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        READ = 2'd1,
        EMIT = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/opt_route.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module opt_route (
    input  logic                       clk,
    input  logic                       reset,
    input  replica_pkg::opt_t          opt_i,
    input  logic                       load_i,
    input  logic [`CITY_DIV_LOG-1:0]   load_word_i,
    input  replica_pkg::replica_data_t word_i,
    input  logic                       emit_i,
    input  logic [`CITY_DIV_LOG-1:0]   emit_word_i,
    output logic                       out_valid_o,
    output replica_pkg::replica_data_t out_data_o
);

    localparam int CITIES   = 1 << `CITY_NUM_LOG;
    localparam int PER_WORD = 1 << `CITY_WORD_LOG;

    replica_pkg::opt_t  opt_q;
    replica_pkg::city_t tour_q [CITIES];

    // Position whose city lands at position p after the move
    function automatic replica_pkg::city_t src_pos(input replica_pkg::opt_t op,
                                                   input replica_pkg::city_t p);
        replica_pkg::city_t a;
        replica_pkg::city_t b;
        replica_pkg::city_t s;
        s = p;
        if (op.kind == replica_pkg::TWO_OPT) begin
            a = op.mv.two_opt.first;
            b = op.mv.two_opt.last;
            if (p >= a && p <= b) s = a + b - p; // Segment reversal
        end else begin
            a = op.mv.or_opt.src;
            b = op.mv.or_opt.dst;
            if (a < b) begin
                if (p >= a && p < b) s = p + 1'b1;
                else if (p == b) s = a;
            end else if (a > b) begin
                if (p == b) s = a;
                else if (p > b && p <= a) s = p - 1'b1;
            end
        end
        return s;
    endfunction

    always_ff @(posedge clk) begin
        if (load_i) begin
            if (load_word_i == '0) opt_q <= opt_i;
            for (int k = 0; k < PER_WORD; k++) begin
                tour_q[{load_word_i, `CITY_WORD_LOG'(k)}] <= word_i[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= emit_i;
        end
        if (emit_i) begin
            for (int k = 0; k < PER_WORD; k++) begin
                out_data_o[k] <= tour_q[src_pos(opt_q, {emit_word_i, `CITY_WORD_LOG'(k)})];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/replica_cfg.svh
`ifndef REPLICA_CFG_SVH
`define REPLICA_CFG_SVH

// ************************************************************
// Tour geometry
// ************************************************************

// 32 cities per tour
`define CITY_NUM_LOG 5

// 8 cities packed per word
`define CITY_WORD_LOG 3

// Words per tour
`define CITY_DIV_LOG (`CITY_NUM_LOG - `CITY_WORD_LOG)

`define BASE_LOG 2 // Replica slots per node

`endif

//--- hdl/replica_pkg.sv
`default_nettype none
`include "replica_cfg.svh"

package replica_pkg;

    typedef logic [`CITY_NUM_LOG-1:0] city_t;

    // Element k holds the city at position word*8+k
    typedef city_t [(1 << `CITY_WORD_LOG)-1:0] replica_data_t;

    typedef enum logic {
        TWO_OPT = 1'b0,
        OR_OPT  = 1'b1
    } move_kind_t;

    // Same two fields, read as segment bounds or as a relocation
    typedef union packed {
        struct packed {
            city_t first;
            city_t last;
        } two_opt;
        struct packed {
            city_t src;
            city_t dst;
        } or_opt;
    } move_u;

    typedef struct packed {
        move_kind_t kind;
        move_u      mv;
    } opt_t;

endpackage

`default_nettype wire

//--- hdl/tour_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module tour_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en_i,
    input  logic [`BASE_LOG-1:0]       wr_base_i,
    input  logic [`CITY_DIV_LOG-1:0]   wr_word_i,
    input  replica_pkg::replica_data_t wr_data_i,
    bank_rd_if.bank                    rd,
    input  logic [`BASE_LOG-1:0]       dd_base_id_i,
    input  replica_pkg::city_t         ordering_addr_i,
    output replica_pkg::city_t         ordering_data_o
);

    localparam int ADDR_W = `BASE_LOG - 1 + `CITY_DIV_LOG;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [ADDR_W-1:0]          wr_addr, ex_addr, dd_addr;
    logic                       wr_bank, ex_bank;
    logic                       ex_bank_q;
    logic [`CITY_WORD_LOG-1:0]  city_sel_q;
    replica_pkg::replica_data_t q [2];
    replica_pkg::replica_data_t dd_word;

    assign wr_bank = wr_base_i[0];
    assign ex_bank = rd.rd_base[0]; // Display always reads the other bank
    assign wr_addr = {wr_base_i[`BASE_LOG-1:1], wr_word_i};
    assign ex_addr = {rd.rd_base[`BASE_LOG-1:1], rd.rd_word};
    assign dd_addr = {dd_base_id_i[`BASE_LOG-1:1],
                      ordering_addr_i[`CITY_NUM_LOG-1:`CITY_WORD_LOG]};

    // ************************************************************
    // Ping-pong RAMs, one write and one read per cycle each
    // ************************************************************
    for (genvar b = 0; b < 2; b++) begin : g_bank
        replica_pkg::replica_data_t mem [DEPTH];

        always_ff @(posedge clk) begin
            if (wr_en_i && (wr_bank == 1'(b))) begin
                mem[wr_addr] <= wr_data_i;
            end
            if (ex_bank == 1'(b)) begin
                if (rd.rd_en) q[b] <= mem[ex_addr];
            end else begin
                q[b] <= mem[dd_addr];
            end
        end
    end

    // Selects travel with the registered read data
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_bank_q <= 1'b0;
        end else begin
            ex_bank_q <= ex_bank;
        end
        city_sel_q <= ordering_addr_i[`CITY_WORD_LOG-1:0];
    end

    assign rd.rd_data      = ex_bank_q ? q[1] : q[0];
    assign dd_word         = ex_bank_q ? q[0] : q[1];
    assign ordering_data_o = dd_word[city_sel_q];

    // Read-during-write on the display bank would return stale data
    a_no_wr_dd_clash : assert property (@(posedge clk) disable iff (reset)
        wr_en_i && (wr_bank != ex_bank) |-> wr_addr != dd_addr);

endmodule

`default_nettype wire

//--- hdl/word_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module word_counter #(
    parameter int unsigned WORDS = 1 << `CITY_DIV_LOG
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en_i,
    output logic [`CITY_DIV_LOG-1:0] count_o,
    output logic                     last_o
);

    assign last_o = (count_o == `CITY_DIV_LOG'(WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count_o <= '0;
        end else if (en_i) begin
            count_o <= last_o ? '0 : count_o + 1'b1; // Wrap after final word
        end
    end

    a_count_range : assert property (@(posedge clk) disable iff (reset)
        count_o < WORDS);

endmodule

`default_nettype wire

//--- sim/exchange_stim.txt
# W src base word0..word3 (src 1=PREV 2=SELF 3=FOLW, words hex)
# C cmd base kind a b busy exp0..exp3 (kind 0=2-opt 1=or-opt) | D base addr city
# Slot 0 identity, slot 1 reversed, slot 2 halves swapped
W 1 0 398a418820 7b9ac5a928 bdab49ca30 ffbbcdeb38
W 2 1 c675be77df 84653a56d7 4254b635cf 00443214c7
W 3 2 bdab49ca30 ffbbcdeb38 398a418820 7b9ac5a928
D 0 5 5
D 0 31 31
D 1 0 31
D 1 20 11
D 2 3 19
D 2 26 10
# 2-opt with i = j, full span, and a short segment with a busy command
C 1 0 0 5 5 0 398a418820 7b9ac5a928 bdab49ca30 ffbbcdeb38
C 2 0 0 0 31 0 c675be77df 84653a56d7 4254b635cf 00443214c7
C 3 1 0 2 5 1 c67bcdebdf 84653a56d7 4254b635cf 00443214c7
# Or-opt with s < d across a word edge, s > d, and s = d with a busy command
C 1 0 1 6 9 0 41ca418820 7b9ac5a8c9 bdab49ca30 ffbbcdeb38
C 2 2 1 20 17 0 bdab49ca30 ffbbcdeb38 398a310480 7b9ac5a928
C 3 2 1 9 9 1 bdab49ca30 ffbbcdeb38 398a418820 7b9ac5a928
# Stored tours stay untouched by commands
D 1 31 0
D 2 16 0

//--- sim/tb_exchange.sv
`timescale 1ns/1ps
`default_nettype none
`include "replica_cfg.svh"

module tb_exchange;

    localparam int    CLK_HALF     = 2;
    localparam int    RESET_CYCLES = 10;
    localparam int    LINE_CYCLES  = 20;
    localparam string STIM_FILE    = "sim/exchange_stim.txt";

    logic                            clk;
    logic                            reset;
    logic [`BASE_LOG-1:0]            dd_base_id_i, ex_base_id_r_i, ex_base_id_w_i;
    exchange_pkg::exchange_command_t command_i, in_ex_com_i, out_ex_com_o;
    replica_pkg::opt_t               opt_i;
    logic                            prev_valid_i, self_valid_i, folw_valid_i;
    replica_pkg::replica_data_t      prev_data_i, self_data_i, folw_data_i;
    logic                            out_valid_o;
    replica_pkg::replica_data_t      out_data_o;
    replica_pkg::city_t              ordering_addr_i, ordering_data_o;

    int                              errors = 0;
    int                              checks = 0;
    int                              limit_cycles = 0;
    exchange_pkg::exchange_command_t last_cmd;
    replica_pkg::replica_data_t      stim_words [4]; // Tour or expected words of the current line

    exchange u_dut (
        .clk             (clk),
        .reset           (reset),
        .dd_base_id_i    (dd_base_id_i),
        .ex_base_id_r_i  (ex_base_id_r_i),
        .ex_base_id_w_i  (ex_base_id_w_i),
        .command_i       (command_i),
        .opt_i           (opt_i),
        .prev_valid_i    (prev_valid_i),
        .prev_data_i     (prev_data_i),
        .self_valid_i    (self_valid_i),
        .self_data_i     (self_data_i),
        .folw_valid_i    (folw_valid_i),
        .folw_data_i     (folw_data_i),
        .in_ex_com_i     (in_ex_com_i),
        .out_valid_o     (out_valid_o),
        .out_data_o      (out_data_o),
        .ordering_addr_i (ordering_addr_i),
        .ordering_data_o (ordering_data_o),
        .out_ex_com_o    (out_ex_com_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: stimulus not finished after %0d cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) c = $fgetc(fd);
    endtask

    // ************************************************************
    // Operations of the stimulus file
    // ************************************************************
    task automatic write_tour(input logic [1:0] src, input logic [`BASE_LOG-1:0] base);
        exchange_pkg::exchange_command_t sel;
        sel = exchange_pkg::exchange_command_t'(src);
        for (int w = 0; w < 4; w++) begin
            @(posedge clk);
            in_ex_com_i    <= sel;
            ex_base_id_w_i <= base;
            dd_base_id_i   <= {~base[1], 1'b0}; // Display away from the written slot
            prev_valid_i   <= 1'b1;             // Unselected sources carry decoys
            self_valid_i   <= 1'b1;
            folw_valid_i   <= 1'b1;
            prev_data_i    <= (sel == exchange_pkg::PREV) ? stim_words[w] : ~stim_words[w];
            self_data_i    <= (sel == exchange_pkg::SELF) ? stim_words[w] : ~stim_words[w];
            folw_data_i    <= (sel == exchange_pkg::FOLW) ? stim_words[w] : ~stim_words[w];
        end
        @(posedge clk);
        in_ex_com_i  <= exchange_pkg::NOP;
        prev_valid_i <= 1'b0;
        self_valid_i <= 1'b0;
        folw_valid_i <= 1'b0;
    endtask

    task automatic show_city(input logic [`BASE_LOG-1:0] base, input replica_pkg::city_t addr,
                             input replica_pkg::city_t expected);
        @(posedge clk);
        ex_base_id_r_i <= {1'b0, ~base[0]}; // Exchange side on the other bank
        dd_base_id_i   <= base;
        repeat (2) @(posedge clk);
        ordering_addr_i <= addr;
        @(posedge clk);
        @(negedge clk);
        check_value("ordering_data_o", expected, ordering_data_o);
    endtask

    task automatic run_command(input logic [1:0] cmd, input logic [`BASE_LOG-1:0] base,
                               input logic kind, input replica_pkg::city_t a,
                               input replica_pkg::city_t b, input logic busy);
        replica_pkg::opt_t               op;
        exchange_pkg::exchange_command_t com;
        exchange_pkg::exchange_command_t extra;
        int                              tail;
        logic                            valid_exp;
        com = exchange_pkg::exchange_command_t'(cmd);
        if (com == exchange_pkg::FOLW) extra = exchange_pkg::PREV;
        else extra = exchange_pkg::exchange_command_t'(cmd + 2'd1);
        op      = '0;
        op.kind = replica_pkg::move_kind_t'(kind);
        if (op.kind == replica_pkg::TWO_OPT) begin
            op.mv.two_opt.first = a;
            op.mv.two_opt.last  = b;
        end else begin
            op.mv.or_opt.src = a;
            op.mv.or_opt.dst = b;
        end
        tail = busy ? 16 : 11;
        @(posedge clk);
        command_i      <= com;
        opt_i          <= op;
        ex_base_id_r_i <= base;
        // Cycle n shows the outputs after edge n-1, edge 0 samples the command
        for (int cyc = 1; cyc <= tail; cyc++) begin
            @(posedge clk);
            command_i <= (busy && cyc == 2) ? extra : exchange_pkg::NOP;
            @(negedge clk);
            valid_exp = (cyc >= 7 && cyc <= 10);
            check_value("out_valid_o", valid_exp, out_valid_o);
            if (valid_exp) check_value("out_data_o", stim_words[cyc-7], out_data_o);
            if (cyc == 2) check_value("out_ex_com_o", last_cmd, out_ex_com_o);
            if (cyc == 3 || cyc == tail) check_value("out_ex_com_o", com, out_ex_com_o);
        end
        last_cmd = com;
    endtask

    // ************************************************************
    // Main sequence
    // ************************************************************
    initial begin
        int                   fd;
        int                   c;
        int                   code;
        int                   lines;
        logic [7:0]           op;
        logic [1:0]           cmd;
        logic [`BASE_LOG-1:0] base;
        logic                 kind;
        logic                 busy;
        replica_pkg::city_t   a;
        replica_pkg::city_t   b;
        void'($urandom(32'h79c6_a198));
        reset           <= 1'b1;
        dd_base_id_i    <= '0;
        ex_base_id_r_i  <= '0;
        ex_base_id_w_i  <= '0;
        command_i       <= exchange_pkg::NOP;
        in_ex_com_i     <= exchange_pkg::NOP;
        opt_i           <= '0;
        prev_valid_i    <= 1'b0;
        self_valid_i    <= 1'b0;
        folw_valid_i    <= 1'b0;
        prev_data_i     <= '0;
        self_data_i     <= '0;
        folw_data_i     <= '0;
        ordering_addr_i <= '0;
        last_cmd = exchange_pkg::NOP;

        lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "\n") lines++;
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        limit_cycles = RESET_CYCLES + LINE_CYCLES * (lines + 1);

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid_o", 1'b0, out_valid_o);
        check_value("out_ex_com_o", exchange_pkg::NOP, out_ex_com_o);

        if (fd != 0) begin
            fd = $fopen(STIM_FILE, "r");
            code = $fscanf(fd, " %c", op);
            while (code == 1) begin
                case (op)
                    "W": begin
                        code = $fscanf(fd, "%d %d %h %h %h %h", cmd, base, stim_words[0],
                                       stim_words[1], stim_words[2], stim_words[3]);
                        if (code == 6) write_tour(cmd, base);
                        else begin
                            $display("stimulus file has a malformed W line");
                            errors++;
                        end
                    end
                    "C": begin
                        code = $fscanf(fd, "%d %d %d %d %d %d %h %h %h %h", cmd, base, kind,
                                       a, b, busy, stim_words[0], stim_words[1],
                                       stim_words[2], stim_words[3]);
                        if (code == 10) run_command(cmd, base, kind, a, b, busy);
                        else begin
                            $display("stimulus file has a malformed C line");
                            errors++;
                        end
                    end
                    "D": begin
                        code = $fscanf(fd, "%d %d %d", base, a, b);
                        if (code == 3) show_city(base, a, b);
                        else begin
                            $display("stimulus file has a malformed D line");
                            errors++;
                        end
                    end
                    "#": skip_line(fd);
                    default: begin
                        $display("stimulus file has an unknown operation %c", op);
                        errors++;
                        skip_line(fd);
                    end
                endcase
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
